//--- verilog/dmem_pkg.sv
package dmem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Bus and memory geometry
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int ADDR_W     = 32;    // Byte address width
  localparam int DATA_W     = 64;    // One doubleword per transfer
  localparam int STRB_W     = 8;     // One strobe bit per byte lane
  localparam int NUM_BANKS  = 4;     // Banks interleaved by doubleword
  localparam int BANK_SEL_W = 2;     // Bank index taken from address bits 4..3
  localparam int BANK_LSB   = 3;     // Lowest bit of the bank index
  localparam int BANK_DEPTH = 256;   // Doublewords held in each bank
  localparam int WORD_IDX_W = 8;     // Word index taken from address bits 12..5
  localparam int IDX_LSB    = 5;     // Lowest bit of the word index
  localparam int MEM_BYTES  = 8192;  // Addresses at or above this are out of range

  // ~~~~~~~~~~~~~~~~~~~~
  // Timing and response codes
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int RD_LATENCY = 3;                       // Cycles spent in the read state
  localparam int LAT_CNT_W  = $clog2(RD_LATENCY);      // Latency counter width
  localparam int QCNT_W     = $clog2(NUM_BANKS + 1);   // Order queue fill level width
  localparam int RESP_W     = 2;

  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;    // Returned for out of range loads

  // Bank FSM encoding
  localparam int              ST_W    = 2;
  localparam logic [ST_W-1:0] ST_IDLE = 2'b00;  // Ready to take a load
  localparam logic [ST_W-1:0] ST_READ = 2'b01;  // Counting out the access latency
  localparam logic [ST_W-1:0] ST_WAIT = 2'b10;  // Holding data until the collector pops it

  // One storage word, seen either as a whole doubleword or as byte lanes
  typedef union packed {
    logic [DATA_W-1:0]          dword;  // Whole word for loads
    logic [STRB_W-1:0][7:0]     bytes;  // Lane view for the strobe merge
  } mem_word_u;

endpackage

//--- verilog/dmem_dispatch.sv
`timescale 1ns/1ps

module dmem_dispatch (
  // Load address channel
  input  logic [dmem_pkg::ADDR_W-1:0]     araddr_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,

  // Store side
  input  logic [dmem_pkg::ADDR_W-1:0]     awaddr_i,
  input  logic                            store_i,

  // Bank status in, one bit per bank
  input  logic [dmem_pkg::NUM_BANKS-1:0]  bank_idle_i,

  // Load strobes and shared load fields
  output logic [dmem_pkg::NUM_BANKS-1:0]  rd_req_o,
  output logic                            rd_err_o,
  output logic [dmem_pkg::WORD_IDX_W-1:0] rd_idx_o,

  // Store strobes and shared store index
  output logic [dmem_pkg::NUM_BANKS-1:0]  wr_req_o,
  output logic [dmem_pkg::WORD_IDX_W-1:0] wr_idx_o,

  // Order queue push toward the collector
  output logic                            push_o,
  output logic [dmem_pkg::BANK_SEL_W-1:0] push_bank_o
);

  import dmem_pkg::*;

  logic [BANK_SEL_W-1:0] rd_bank;   // Target bank of the load address
  logic [BANK_SEL_W-1:0] wr_bank;   // Target bank of the store address
  logic                  wr_err;    // Store lands outside the memory
  logic                  rd_fire;   // Load handshake in this cycle

  // ~~~~~~~~~~~~~~~~~~~~
  // Address split
  // ~~~~~~~~~~~~~~~~~~~~
  // Bits 2..0 pick a byte inside the doubleword and are not needed here
  assign rd_bank  = araddr_i[BANK_LSB +: BANK_SEL_W];
  assign rd_idx_o = araddr_i[IDX_LSB +: WORD_IDX_W];
  assign wr_bank  = awaddr_i[BANK_LSB +: BANK_SEL_W];
  assign wr_idx_o = awaddr_i[IDX_LSB +: WORD_IDX_W];

  // Range check against the full byte address
  assign rd_err_o = (araddr_i >= ADDR_W'(MEM_BYTES));  // The bank still answers, with an error
  assign wr_err   = (awaddr_i >= ADDR_W'(MEM_BYTES));  // Such a store is dropped here

  // ~~~~~~~~~~~~~~~~~~~~
  // Load acceptance
  // ~~~~~~~~~~~~~~~~~~~~
  // A load is only taken when its own bank has nothing in flight
  assign arready_o = bank_idle_i[rd_bank];
  assign rd_fire   = arvalid_i && arready_o;

  // One-hot strobe to the selected bank
  always_comb begin
    rd_req_o = '0;
    if (rd_fire) begin
      rd_req_o[rd_bank] = 1'b1;
    end
  end

  // Every accepted load records its bank so responses come back in order
  assign push_o      = rd_fire;
  assign push_bank_o = rd_bank;

  // ~~~~~~~~~~~~~~~~~~~~
  // Store steering
  // ~~~~~~~~~~~~~~~~~~~~
  // Stores are never stalled, so the strobe goes out in the same cycle
  always_comb begin
    wr_req_o = '0;
    if (store_i && !wr_err) begin
      wr_req_o[wr_bank] = 1'b1;  // Out of range stores raise no strobe at all
    end
  end

endmodule

//--- verilog/dmem_bank.sv
`timescale 1ns/1ps

module dmem_bank (
  input  logic                            clk,
  input  logic                            rst,

  // Load side from the dispatcher
  input  logic                            rd_req_i,   // Strobe for this bank only
  input  logic                            rd_err_i,   // Address was out of range
  input  logic [dmem_pkg::WORD_IDX_W-1:0] rd_idx_i,

  // Store side from the dispatcher
  input  logic                            wr_req_i,   // Strobe for this bank only
  input  logic [dmem_pkg::WORD_IDX_W-1:0] wr_idx_i,
  input  logic [dmem_pkg::DATA_W-1:0]     wdata_i,
  input  logic [dmem_pkg::STRB_W-1:0]     wstrb_i,

  // Drain from the collector
  input  logic                            pop_i,

  // Status and response
  output logic                            idle_o,
  output logic                            rvalid_o,
  output logic [dmem_pkg::DATA_W-1:0]     rdata_o,
  output logic [dmem_pkg::RESP_W-1:0]     rresp_o
);

  import dmem_pkg::*;

  mem_word_u             mem_q [BANK_DEPTH];   // Bank storage
  mem_word_u             wr_word;              // Store data in lane view
  logic [ST_W-1:0]       state_q;
  logic [ST_W-1:0]       state_d;
  logic [LAT_CNT_W-1:0]  lat_cnt_q;            // Cycles already spent in read
  logic                  rd_fire;              // Load taken on this edge
  logic                  lat_done;             // Last read cycle

  assign wr_word = wdata_i;

  // ~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~
  // Only the enabled byte lanes are written, the rest of the word keeps its value
  always_ff @(posedge clk) begin
    if (wr_req_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem_q[wr_idx_i].bytes[b] <= wr_word.bytes[b];
        end
      end
    end
  end

  // Read the array on the accepting edge
  // A store to the same word on that edge is not seen, the old word is captured
  assign rd_fire = rd_req_i && (state_q == ST_IDLE);

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      if (rd_err_i) begin
        rdata_o <= '0;
        rresp_o <= RESP_SLVERR;
      end else begin
        rdata_o <= mem_q[rd_idx_i].dword;
        rresp_o <= RESP_OKAY;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Latency FSM
  // ~~~~~~~~~~~~~~~~~~~~
  assign lat_done = (lat_cnt_q == LAT_CNT_W'(RD_LATENCY - 1));

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;  // Hold by default
    case (state_q)
      ST_IDLE: begin
        if (rd_fire) begin
          state_d = ST_READ;
        end
      end
      ST_READ: begin
        if (lat_done) begin
          state_d = ST_WAIT;  // Data is now presented to the collector
        end
      end
      ST_WAIT: begin
        if (pop_i) begin
          state_d = ST_IDLE;  // Free for a new load from the next cycle
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Counter runs only while reading and restarts from zero for every load
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      lat_cnt_q <= '0;
    end else if (state_q == ST_READ) begin
      lat_cnt_q <= lat_cnt_q + 1'b1;
    end else begin
      lat_cnt_q <= '0;
    end
  end

  assign idle_o   = (state_q == ST_IDLE);
  assign rvalid_o = (state_q == ST_WAIT);  // Held until the pop, so data stays stable

endmodule

//--- verilog/dmem_collect.sv
`timescale 1ns/1ps

module dmem_collect (
  input  logic                                              clk,
  input  logic                                              rst,

  // Push from the dispatcher, one per accepted load
  input  logic                                              push_i,
  input  logic [dmem_pkg::BANK_SEL_W-1:0]                   push_bank_i,

  // Responses of all banks, one slice per bank
  input  logic [dmem_pkg::NUM_BANKS-1:0]                    bank_rvalid_i,
  input  logic [dmem_pkg::NUM_BANKS-1:0][dmem_pkg::DATA_W-1:0] bank_rdata_i,
  input  logic [dmem_pkg::NUM_BANKS-1:0][dmem_pkg::RESP_W-1:0] bank_rresp_i,

  // Load response channel
  input  logic                                              rready_i,
  output logic                                              rvalid_o,
  output logic [dmem_pkg::DATA_W-1:0]                       rdata_o,
  output logic [dmem_pkg::RESP_W-1:0]                       rresp_o,

  // Drain strobe back to the banks
  output logic [dmem_pkg::NUM_BANKS-1:0]                    bank_pop_o
);

  import dmem_pkg::*;

  logic [BANK_SEL_W-1:0] order_q [NUM_BANKS];  // Bank indices in acceptance order
  logic [BANK_SEL_W-1:0] head_q;               // Oldest outstanding load
  logic [BANK_SEL_W-1:0] tail_q;               // Next free slot
  logic [QCNT_W-1:0]     count_q;              // Loads still waiting to be returned
  logic [BANK_SEL_W-1:0] head_bank;
  logic                  pop;                  // Response handshake in this cycle

  // ~~~~~~~~~~~~~~~~~~~~
  // Head selection
  // ~~~~~~~~~~~~~~~~~~~~
  assign head_bank = order_q[head_q];

  // Only the head bank may answer, younger banks that finished early keep waiting
  assign rvalid_o = (count_q != '0) && bank_rvalid_i[head_bank];
  assign rdata_o  = bank_rdata_i[head_bank];
  assign rresp_o  = bank_rresp_i[head_bank];

  assign pop = rvalid_o && rready_i;

  always_comb begin
    bank_pop_o = '0;
    if (pop) begin
      bank_pop_o[head_bank] = 1'b1;  // Release the bank in the handshake cycle
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Order queue
  // ~~~~~~~~~~~~~~~~~~~~
  // One slot per bank is enough since a busy bank takes no second load
  always_ff @(posedge clk) begin
    if (push_i) begin
      order_q[tail_q] <= push_bank_i;
    end
  end

  // Pointers wrap naturally, NUM_BANKS is a power of two
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither leaves the level unchanged
      endcase
    end
  end

endmodule

//--- verilog/dmem_top.sv
`timescale 1ns/1ps

module dmem_top (
  input  logic                            clk,
  input  logic                            rst,

  // Load address channel
  input  logic [dmem_pkg::ADDR_W-1:0]     araddr_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,

  // Load response channel
  output logic [dmem_pkg::DATA_W-1:0]     rdata_o,
  output logic [dmem_pkg::RESP_W-1:0]     rresp_o,
  output logic                            rvalid_o,
  input  logic                            rready_i,

  // Store strobe, always accepted
  input  logic                            store_i,
  input  logic [dmem_pkg::ADDR_W-1:0]     awaddr_i,
  input  logic [dmem_pkg::DATA_W-1:0]     wdata_i,
  input  logic [dmem_pkg::STRB_W-1:0]     wstrb_i
);

  import dmem_pkg::*;

  // Dispatcher to banks
  logic [NUM_BANKS-1:0]              bank_rd_req;   // One-hot load strobe
  logic [NUM_BANKS-1:0]              bank_wr_req;   // One-hot store strobe
  logic                              rd_err;
  logic [WORD_IDX_W-1:0]             rd_idx;
  logic [WORD_IDX_W-1:0]             wr_idx;

  // Banks back to dispatcher and collector
  logic [NUM_BANKS-1:0]              bank_idle;
  logic [NUM_BANKS-1:0]              bank_rvalid;
  logic [NUM_BANKS-1:0][DATA_W-1:0]  bank_rdata;
  logic [NUM_BANKS-1:0][RESP_W-1:0]  bank_rresp;

  // Order tracking
  logic                              push;
  logic [BANK_SEL_W-1:0]             push_bank;
  logic [NUM_BANKS-1:0]              bank_pop;

  dmem_dispatch i_dmem_dispatch (
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .awaddr_i    (awaddr_i),
    .store_i     (store_i),
    .bank_idle_i (bank_idle),
    .rd_req_o    (bank_rd_req),
    .rd_err_o    (rd_err),
    .rd_idx_o    (rd_idx),
    .wr_req_o    (bank_wr_req),
    .wr_idx_o    (wr_idx),
    .push_o      (push),
    .push_bank_o (push_bank)
  );

  // Identical banks, each sees the shared fields and only its own strobes
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    dmem_bank i_dmem_bank (
      .clk      (clk),
      .rst      (rst),
      .rd_req_i (bank_rd_req[g]),
      .rd_err_i (rd_err),
      .rd_idx_i (rd_idx),
      .wr_req_i (bank_wr_req[g]),
      .wr_idx_i (wr_idx),
      .wdata_i  (wdata_i),
      .wstrb_i  (wstrb_i),
      .pop_i    (bank_pop[g]),
      .idle_o   (bank_idle[g]),
      .rvalid_o (bank_rvalid[g]),
      .rdata_o  (bank_rdata[g]),
      .rresp_o  (bank_rresp[g])
    );
  end

  dmem_collect i_dmem_collect (
    .clk           (clk),
    .rst           (rst),
    .push_i        (push),
    .push_bank_i   (push_bank),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata),
    .bank_rresp_i  (bank_rresp),
    .rready_i      (rready_i),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .rresp_o       (rresp_o),
    .bank_pop_o    (bank_pop)
  );

endmodule

//--- tb/dmem_tb_tests.svh
`ifndef DMEM_TB_TESTS_SVH
`define DMEM_TB_TESTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Bus helpers
// ~~~~~~~~~~~~~~~~~~~~
task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic [STRB_W-1:0] strb);
  @(posedge clk);
  store  <= 1'b1;  // One-cycle strobe, never stalled
  awaddr <= addr;
  wdata  <= data;
  wstrb  <= strb;
  @(posedge clk);
  store  <= 1'b0;
  model_store(addr, data, strb);
endtask

// Presents a load and returns on the edge where it is taken
task automatic issue_load(input logic [ADDR_W-1:0] addr);
  @(posedge clk);
  araddr  <= addr;
  arvalid <= 1'b1;
  do @(negedge clk); while (!arready);
  @(posedge clk);
  arvalid <= 1'b0;
endtask

// Samples at the falling edge, the transfer itself happens on the next rising edge
task automatic get_response(output logic [DATA_W-1:0] data, output logic [RESP_W-1:0] resp);
  do @(negedge clk); while (!(rvalid && rready));
  data = rdata;
  resp = rresp;
  @(posedge clk);
endtask

task automatic load_and_check(input string name, input logic [ADDR_W-1:0] addr);
  mem_word_u         exp;
  logic [DATA_W-1:0] data;
  logic [RESP_W-1:0] resp;
  exp = model_word(addr);
  issue_load(addr);
  get_response(data, resp);
  check_data(name, exp.dword, data);
  check_resp(name, RESP_OKAY, resp);
endtask

function automatic logic [ADDR_W-1:0] rand_addr();
  return ADDR_W'(next_rand() % MEM_BYTES) & ~ADDR_W'(7);  // Aligned and in range
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~
// Pattern built from the full word address so every word is distinct
task automatic fill_memory();
  logic [ADDR_W-1:0] addr;
  for (int w = 0; w < MEM_BYTES / 8; w++) begin
    addr = ADDR_W'(w * 8);
    store_word(addr, {~addr, addr ^ 32'h5a3c_0000}, '1);
  end
endtask

task automatic full_word_roundtrip();
  logic [ADDR_W-1:0] addr;
  for (int i = 0; i < 24; i++) begin
    addr = rand_addr();
    addr[4:3] = 2'(i % NUM_BANKS);  // Walk through every bank
    store_word(addr, {next_rand(), next_rand()}, '1);
    load_and_check("full_word", addr);
  end
endtask

task automatic partial_strobe_merge();
  logic [ADDR_W-1:0] addr;
  for (int i = 0; i < 16; i++) begin
    addr = rand_addr();
    store_word(addr, {next_rand(), next_rand()}, 8'(next_rand()));
    load_and_check("partial_strobe", addr);
  end
endtask

task automatic out_of_range_access();
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  logic [RESP_W-1:0] resp;
  for (int i = 0; i < 6; i++) begin
    addr = ADDR_W'(MEM_BYTES) + (next_rand() & 32'h00ff_fff8);
    issue_load(addr);
    get_response(data, resp);
    check_data("out_of_range", '0, data);
    check_resp("out_of_range", RESP_SLVERR, resp);
  end
  // Address 8 KiB would alias word 0 of bank 0 without the range check
  store_word(ADDR_W'(MEM_BYTES), {next_rand(), next_rand()}, '1);
  load_and_check("out_of_range_store", '0);
endtask

task automatic pipelined_bank_loads();
  logic [ADDR_W-1:0] base;
  logic [DATA_W-1:0] exp [NUM_BANKS];
  logic [DATA_W-1:0] data;
  logic [RESP_W-1:0] resp;
  mem_word_u         w;
  for (int r = 0; r < 4; r++) begin
    base = rand_addr() & ~ADDR_W'(31);  // Start on bank 0
    for (int i = 0; i < NUM_BANKS; i++) begin
      w = model_word(base + ADDR_W'(i * 8));
      exp[i] = w.dword;
    end
    fork
      begin
        for (int i = 0; i < NUM_BANKS; i++) begin
          @(posedge clk);
          araddr  <= base + ADDR_W'(i * 8);
          arvalid <= 1'b1;
          @(negedge clk);
          // Every bank is idle here, so each load must go in on the very next edge
          if (!arready) begin
            error_count++;
            $display("Pipelined load %0d was not accepted back to back", i);
          end
          while (!arready) begin
            @(negedge clk);
          end
        end
        @(posedge clk);
        arvalid <= 1'b0;
      end
      begin
        for (int i = 0; i < NUM_BANKS; i++) begin
          get_response(data, resp);
          check_data("pipelined", exp[i], data);
          check_resp("pipelined", RESP_OKAY, resp);
        end
      end
    join
  end
endtask

task automatic rready_back_pressure();
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  logic [RESP_W-1:0] resp;
  mem_word_u         exp_a;
  mem_word_u         exp_b;
  int                stall;
  for (int r = 0; r < 8; r++) begin
    addr  = rand_addr();
    exp_a = model_word(addr);
    exp_b = model_word((addr + 32) % MEM_BYTES);  // Next word of the same bank
    @(posedge clk);
    rready <= 1'b0;
    issue_load(addr);
    @(posedge clk);
    araddr  <= (addr + 32) % MEM_BYTES;
    arvalid <= 1'b1;
    do begin
      @(negedge clk);
      if (arready) begin
        error_count++;
        $display("Second load to a busy bank was accepted before its first load returned");
      end
    end while (!rvalid);
    stall = 2 + int'(next_rand() % 8);
    for (int s = 0; s < stall; s++) begin
      @(negedge clk);
      if (!rvalid || arready) begin
        error_count++;
        $display("Response dropped or bank freed while the response was stalled");
      end
      check_data("back_pressure_hold", exp_a.dword, rdata);
    end
    @(posedge clk);
    rready <= 1'b1;
    get_response(data, resp);
    check_data("back_pressure_a", exp_a.dword, data);
    check_resp("back_pressure_a", RESP_OKAY, resp);
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    get_response(data, resp);
    check_data("back_pressure_b", exp_b.dword, data);
    check_resp("back_pressure_b", RESP_OKAY, resp);
  end
endtask

task automatic store_during_pending_load();
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  logic [RESP_W-1:0] resp;
  mem_word_u         old_word;
  for (int i = 0; i < 8; i++) begin
    addr = rand_addr();
    old_word = model_word(addr);
    issue_load(addr);
    store_word(addr, {next_rand(), next_rand()}, '1);  // Lands while the load is pending
    get_response(data, resp);
    check_data("store_during_load", old_word.dword, data);
    load_and_check("store_during_load_new", addr);
  end
endtask

`endif

//--- tb/dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb;

  import dmem_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_OPS    = 1024 + 400;  // Memory fill plus all directed operations
  localparam int WATCHDOG   = NUM_OPS * 20 * CLK_PERIOD + 2000;  // In ns, with a margin

  logic                  clk;
  logic                  rst;
  logic [ADDR_W-1:0]     araddr;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_W-1:0]     rdata;
  logic [RESP_W-1:0]     rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  store;
  logic [ADDR_W-1:0]     awaddr;
  logic [DATA_W-1:0]     wdata;
  logic [STRB_W-1:0]     wstrb;

  logic [7:0]            ref_mem [MEM_BYTES];  // Byte model of the whole memory
  logic [31:0]           rng_state;
  int                    error_count;

  // ~~~~~~~~~~~~~~~~~~~~
  // Clock and DUT
  // ~~~~~~~~~~~~~~~~~~~~
  always #(CLK_PERIOD / 2) clk = ~clk;

  dmem_top i_dmem_top (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .store_i   (store),
    .awaddr_i  (awaddr),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Model, random numbers and compares
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // Classic LCG constants
    return rng_state;
  endfunction

  // Doubleword the model holds at the word of this address
  function automatic mem_word_u model_word(input logic [ADDR_W-1:0] addr);
    mem_word_u   w;
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    for (int b = 0; b < STRB_W; b++) begin
      w.bytes[b] = ref_mem[base + b];
    end
    return w;
  endfunction

  // Stores outside the memory leave the model untouched
  function automatic void model_store(input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data,
                                      input logic [STRB_W-1:0] strb);
    mem_word_u   w;
    logic [31:0] base;
    w = data;
    base = {addr[31:3], 3'b000};
    if (addr < ADDR_W'(MEM_BYTES)) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) ref_mem[base + b] = w.bytes[b];
      end
    end
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      error_count++;
      $display("error %s data expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [RESP_W-1:0] exp,
                            input logic [RESP_W-1:0] act);
    if (act !== exp) begin
      error_count++;
      $display("error %s resp expected %0d actual %0d", name, exp, act);
    end
  endtask

  `include "dmem_tb_tests.svh"

  // Ends a run that stopped making progress
  initial begin
    #(WATCHDOG);
    $display("Watchdog expired, the DUT stopped responding");
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    clk = 1'b0;
    rst = 1'b0;  // Held in reset from time zero
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    store = 1'b0;
    awaddr = '0;
    wdata = '0;
    wstrb = '0;
    rng_state = 32'h9c5f_187b;
    error_count = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    fill_memory();
    full_word_roundtrip();
    partial_strobe_merge();
    out_of_range_access();
    pipelined_bank_loads();
    rready_back_pressure();
    store_during_pending_load();
    repeat (4) @(posedge clk);
    $display("Run finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+tb
verilog/dmem_pkg.sv
verilog/dmem_dispatch.sv
verilog/dmem_bank.sv
verilog/dmem_collect.sv
verilog/dmem_top.sv
tb/dmem_tb.sv

//--- Makefile
# Verilator build for the banked data memory testbench

TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = dmem_tb
RTL_TOP   = dmem_top
FILE_LIST = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = \*\*\* TEST PASSED \*\*\*

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
